// File: source/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // Default widths, handed down by the top level
    localparam int NB_DATA_DEF    = 32;
    localparam int NB_PC_DEF      = 32;
    localparam int NB_REG_DEF     = 5;
    localparam int NB_DM_ADDR_DEF = 5;       // 32 bytes of data memory

    localparam int NB_BYTE = 8;
    localparam int N_LANES = NB_DATA_DEF / NB_BYTE;    // Byte lanes per word

    typedef logic [NB_DATA_DEF-1:0] data_word_t;
    typedef logic [NB_PC_DEF-1:0]   pc_t;
    typedef logic [NB_REG_DEF-1:0]  reg_idx_t;
    typedef logic [NB_BYTE-1:0]     lane_byte_t;

    // Control flags coming from EX/MEM
    typedef struct packed {
        logic reg_write;        // WB writes the register file
        logic mem_to_reg;       // WB takes memory data
        logic mem_read;
        logic mem_write;
        logic word_en;          // Access size, one-hot
        logic halfword_en;
        logic byte_en;
        logic load_unsigned;    // lbu / lhu
        logic branch;
        logic r31_ctrl;         // Link register write (jal)
        logic hlt;
    } mem_ctrl_t;

    // Write request for one byte lane
    typedef struct packed {
        logic       we;
        lane_byte_t wdata;
    } lane_wr_t;

    // Fields forwarded to write back
    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;
        logic       r31_ctrl;
        logic       hlt;
        reg_idx_t   selected_reg;   // rd or rt
        data_word_t alu_result;
        pc_t        pc;
    } wb_bundle_t;

endpackage

`default_nettype wire

// File: source/store_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module store_aligner
    import mem_stage_pkg::*;
#(
    parameter int  NB_DM_ADDR = NB_DM_ADDR_DEF,
    localparam int NB_OFFSET  = (NB_DM_ADDR < $clog2(N_LANES)) ? NB_DM_ADDR : $clog2(N_LANES)
) (
    input  mem_ctrl_t                i_ctrl,
    input  logic                     i_dm_enable,   // Debug unit run enable
    input  logic [NB_OFFSET-1:0]     i_addr_low,    // Byte offset inside the word
    input  data_word_t               i_write_data,
    output lane_wr_t [N_LANES-1:0]   o_lane_wr
);

    logic               strobe;
    logic [1:0]         offset;
    logic [N_LANES-1:0] lane_sel;
    data_word_t         lane_data;

    assign strobe = i_dm_enable & i_ctrl.mem_write;    // Single qualified store strobe
    assign offset = 2'(i_addr_low);

    // Size and offset pick the lanes, data is replicated so any lane sees its byte
    always_comb begin
        lane_sel  = '0;
        lane_data = i_write_data;
        if (i_ctrl.byte_en) begin
            lane_sel[offset] = 1'b1;
            lane_data        = {N_LANES{i_write_data[NB_BYTE-1:0]}};
        end else if (i_ctrl.halfword_en) begin
            lane_sel  = offset[1] ? 4'b1100 : 4'b0011;    // Bit 0 ignored
            lane_data = {2{i_write_data[2*NB_BYTE-1:0]}};
        end else if (i_ctrl.word_en) begin
            lane_sel  = '1;
            lane_data = i_write_data;
        end
    end

    for (genvar k = 0; k < N_LANES; k++) begin : g_lane
        assign o_lane_wr[k].we    = strobe & lane_sel[k];
        assign o_lane_wr[k].wdata = lane_data[k*NB_BYTE +: NB_BYTE];
    end

endmodule

`default_nettype wire

// File: source/byte_lane_bank.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_bank
    import mem_stage_pkg::*;
#(
    parameter int  DEPTH  = 8,                  // Words in the memory
    localparam int NB_IDX = $clog2(DEPTH)
) (
    input  logic              i_clock,
    input  logic              i_rst_n,
    input  lane_wr_t          i_wr,
    input  logic [NB_IDX-1:0] i_index,          // Pipeline word index
    input  logic [NB_IDX-1:0] i_dbg_index,      // Debug word index
    output lane_byte_t        o_rdata,
    output lane_byte_t        o_dbg_rdata
);

    lane_byte_t mem [DEPTH];

    // Whole lane clears while reset is low
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr.we) begin
            mem[i_index] <= i_wr.wdata;
        end
    end

    assign o_rdata     = mem[i_index];      // Load path
    assign o_dbg_rdata = mem[i_dbg_index];  // Debug path

endmodule

`default_nettype wire

// File: source/load_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module load_extractor
    import mem_stage_pkg::*;
#(
    parameter int NB_DATA = NB_DATA_DEF
) (
    input  lane_byte_t [N_LANES-1:0] i_lane_rdata,     // Lane k is byte k of the word
    input  lane_byte_t [N_LANES-1:0] i_lane_dbg,
    input  logic [1:0]               i_addr_low,
    input  mem_ctrl_t                i_ctrl,
    input  logic                     i_dm_read_enable,
    output data_word_t               o_mem_data,
    output data_word_t               o_debug_word
);

    localparam int NB_HALF = 2 * NB_BYTE;

    lane_byte_t         sel_byte;
    logic [NB_HALF-1:0] sel_half;
    data_word_t         sel_word;
    logic               byte_fill;
    logic               half_fill;

    assign sel_byte = i_lane_rdata[i_addr_low];
    assign sel_word = data_word_t'(i_lane_rdata);

    // Upper or lower halfword, bit 0 of the address is ignored
    always_comb begin
        if (i_addr_low[1]) begin
            sel_half = {i_lane_rdata[3], i_lane_rdata[2]};
        end else begin
            sel_half = {i_lane_rdata[1], i_lane_rdata[0]};
        end
    end

    // Zero fill for lbu and lhu
    assign byte_fill = ~i_ctrl.load_unsigned & sel_byte[NB_BYTE-1];
    assign half_fill = ~i_ctrl.load_unsigned & sel_half[NB_HALF-1];

    always_comb begin
        o_mem_data = '0;
        if (i_ctrl.mem_read) begin
            if (i_ctrl.byte_en) begin
                o_mem_data = {{(NB_DATA-NB_BYTE){byte_fill}}, sel_byte};
            end else if (i_ctrl.halfword_en) begin
                o_mem_data = {{(NB_DATA-NB_HALF){half_fill}}, sel_half};
            end else if (i_ctrl.word_en) begin
                o_mem_data = sel_word;
            end
        end
    end

    // Debug word in little-endian lane order
    always_comb begin
        o_debug_word = '0;
        if (i_dm_read_enable) begin
            for (int k = 0; k < N_LANES; k++) begin
                o_debug_word[k*NB_BYTE +: NB_BYTE] = i_lane_dbg[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import mem_stage_pkg::*;
#(
    parameter int NB_DATA    = NB_DATA_DEF,
    parameter int NB_PC      = NB_PC_DEF,
    parameter int NB_REG     = NB_REG_DEF,
    parameter int NB_DM_ADDR = NB_DM_ADDR_DEF
) (
    input  logic                  i_clock,
    input  logic                  i_rst_n,

    // EX/MEM bundle
    input  mem_ctrl_t             i_ctrl,
    input  logic [NB_DATA-1:0]    i_alu_result,       // Memory address or R-type result
    input  logic [NB_DATA-1:0]    i_write_data,       // Store data, rt
    input  logic [NB_PC-1:0]      i_branch_addr,
    input  logic                  i_zero,             // ALU zero flag
    input  logic [NB_REG-1:0]     i_selected_reg,     // rd or rt
    input  logic [NB_PC-1:0]      i_pc,

    // Debug unit
    input  logic                  i_dm_enable,
    input  logic                  i_dm_read_enable,
    input  logic [NB_DM_ADDR-1:0] i_dm_read_address,  // Byte address, low bits ignored

    output data_word_t            o_mem_data,
    output data_word_t            o_debug_word,
    output pc_t                   o_branch_addr,      // To IF
    output logic                  o_branch_taken,     // IF PC mux select
    output wb_bundle_t            o_wb
);

    localparam int NB_OFFSET = $clog2(N_LANES);
    localparam int NB_IDX    = NB_DM_ADDR - NB_OFFSET;
    localparam int DEPTH     = (2 ** NB_DM_ADDR) / N_LANES;     // Words per lane

    logic [NB_DM_ADDR-1:0]    dm_addr;
    logic [NB_OFFSET-1:0]     addr_low;
    logic [NB_IDX-1:0]        word_index;
    logic [NB_IDX-1:0]        dbg_index;

    lane_wr_t   [N_LANES-1:0] lane_wr;
    lane_byte_t [N_LANES-1:0] lane_rdata;
    lane_byte_t [N_LANES-1:0] lane_dbg;

    // Memory address is the low part of the ALU result
    assign dm_addr    = i_alu_result[NB_DM_ADDR-1:0];
    assign addr_low   = dm_addr[NB_OFFSET-1:0];
    assign word_index = dm_addr[NB_DM_ADDR-1:NB_OFFSET];
    assign dbg_index  = i_dm_read_address[NB_DM_ADDR-1:NB_OFFSET];

    store_aligner #(
        .NB_DM_ADDR (NB_DM_ADDR)
    ) store_aligner_inst (
        .i_ctrl       (i_ctrl),
        .i_dm_enable  (i_dm_enable),
        .i_addr_low   (addr_low),
        .i_write_data (i_write_data),
        .o_lane_wr    (lane_wr)
    );

    // One bank per byte lane
    for (genvar k = 0; k < N_LANES; k++) begin : g_bank
        byte_lane_bank #(
            .DEPTH (DEPTH)
        ) byte_lane_bank_inst (
            .i_clock     (i_clock),
            .i_rst_n     (i_rst_n),
            .i_wr        (lane_wr[k]),
            .i_index     (word_index),
            .i_dbg_index (dbg_index),
            .o_rdata     (lane_rdata[k]),
            .o_dbg_rdata (lane_dbg[k])
        );
    end

    load_extractor #(
        .NB_DATA (NB_DATA)
    ) load_extractor_inst (
        .i_lane_rdata     (lane_rdata),
        .i_lane_dbg       (lane_dbg),
        .i_addr_low       (addr_low),
        .i_ctrl           (i_ctrl),
        .i_dm_read_enable (i_dm_read_enable),
        .o_mem_data       (o_mem_data),
        .o_debug_word     (o_debug_word)
    );

    // Branch resolves here, beq/bne polarity is settled in EX
    assign o_branch_taken = i_ctrl.branch & i_zero;
    assign o_branch_addr  = i_branch_addr;

    // Write-back pass-through
    always_comb begin
        o_wb.reg_write    = i_ctrl.reg_write;
        o_wb.mem_to_reg   = i_ctrl.mem_to_reg;
        o_wb.r31_ctrl     = i_ctrl.r31_ctrl;
        o_wb.hlt          = i_ctrl.hlt;
        o_wb.selected_reg = i_selected_reg;
        o_wb.alu_result   = i_alu_result;     // Only used for non-loads
        o_wb.pc           = i_pc;             // Return address for jal
    end

endmodule

`default_nettype wire

// File: verification/mem_stage_tb_vectors.svh
// Each row holds ctrl, address, store data, zero, branch address, dm_enable,
// dm_read_enable, debug address, expected mem data, expected debug word and expected taken
`ifndef MEM_STAGE_TB_VECTORS_SVH
`define MEM_STAGE_TB_VECTORS_SVH

task automatic build_vectors();
    // Every word reads zero after reset
    for (int w = 0; w < 8; w++) begin
        add_row(CTRL_LW, 4 * w, 32'h0, 0, 32'h0, 1, 1, 5'(4 * w), 32'h0, 32'h0, 0);
    end

    // Word store then loads of every size and offset
    add_row(CTRL_SW,  32'h04, 32'hC37F_9A15, 0, 32'h0, 1, 1, 5'h04, 32'h0,         32'h0,         0);
    add_row(CTRL_LW,  32'h04, 32'h0,         1, 32'h0, 1, 1, 5'h04, 32'hC37F_9A15, 32'hC37F_9A15, 0);
    add_row(CTRL_LB,  32'h04, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_0015, 32'h0,         0);
    add_row(CTRL_LB,  32'h05, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'hFFFF_FF9A, 32'h0,         0);
    add_row(CTRL_LB,  32'h06, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_007F, 32'h0,         0);
    add_row(CTRL_LB,  32'h07, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'hFFFF_FFC3, 32'h0,         0);
    add_row(CTRL_LBU, 32'h04, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_0015, 32'h0,         0);
    add_row(CTRL_LBU, 32'h05, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_009A, 32'h0,         0);
    add_row(CTRL_LBU, 32'h07, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_00C3, 32'h0,         0);
    add_row(CTRL_LH,  32'h04, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'hFFFF_9A15, 32'h0,         0);
    add_row(CTRL_LH,  32'h06, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'hFFFF_C37F, 32'h0,         0);
    add_row(CTRL_LHU, 32'h04, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_9A15, 32'h0,         0);
    add_row(CTRL_LHU, 32'h07, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0000_C37F, 32'h0,         0);
    add_row(CTRL_LH,  32'h05, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'hFFFF_9A15, 32'h0,         0);

    // Partial stores merge into their own lanes only
    add_row(CTRL_SW,  32'h08, 32'h1122_3344, 0, 32'h0, 1, 1, 5'h04, 32'h0,         32'hC37F_9A15, 0);
    add_row(CTRL_SB,  32'h09, 32'hFFFF_FFA5, 0, 32'h0, 1, 1, 5'h08, 32'h0,         32'h1122_3344, 0);
    add_row(CTRL_SH,  32'h0A, 32'h1234_BEEF, 0, 32'h0, 1, 1, 5'h08, 32'h0,         32'h1122_A544, 0);
    add_row(CTRL_LW,  32'h08, 32'h0,         0, 32'h0, 1, 1, 5'h08, 32'hBEEF_A544, 32'hBEEF_A544, 0);
    add_row(CTRL_SB,  32'h08, 32'h0000_0077, 0, 32'h0, 1, 1, 5'h0C, 32'h0,         32'h0,         0);
    add_row(CTRL_SH,  32'h0C, 32'h0000_CAFE, 0, 32'h0, 1, 1, 5'h08, 32'h0,         32'hBEEF_A577, 0);
    add_row(CTRL_LH,  32'h0C, 32'h0,         0, 32'h0, 1, 1, 5'h0C, 32'hFFFF_CAFE, 32'h0000_CAFE, 0);
    add_row(CTRL_LBU, 32'h0B, 32'h0,         1, 32'h0, 1, 1, 5'h04, 32'h0000_00BE, 32'hC37F_9A15, 0);
    add_row(CTRL_SB,  32'h0E, 32'h0000_0033, 0, 32'h0, 1, 1, 5'h0C, 32'h0,         32'h0000_CAFE, 0);
    add_row(CTRL_SB,  32'h0F, 32'h0000_0081, 0, 32'h0, 1, 1, 5'h0C, 32'h0,         32'h0033_CAFE, 0);
    add_row(CTRL_LB,  32'h0F, 32'h0,         0, 32'h0, 1, 1, 5'h0C, 32'hFFFF_FF81, 32'h8133_CAFE, 0);

    // Gated store and disabled read paths
    add_row(CTRL_SW,  32'h10, 32'hDEAD_BEEF, 0, 32'h0, 0, 1, 5'h10, 32'h0,         32'h0,         0);
    add_row(CTRL_LW,  32'h10, 32'h0,         0, 32'h0, 1, 1, 5'h10, 32'h0,         32'h0,         0);
    add_row(CTRL_SB,  32'h10, 32'h0000_005A, 0, 32'h0, 0, 1, 5'h10, 32'h0,         32'h0,         0);
    add_row(CTRL_LBU, 32'h10, 32'h0,         0, 32'h0, 1, 1, 5'h10, 32'h0,         32'h0,         0);
    add_row(CTRL_WNR, 32'h04, 32'h0,         0, 32'h0, 1, 0, 5'h04, 32'h0,         32'h0,         0);
    add_row(CTRL_LW,  32'h04, 32'h0,         0, 32'h0, 0, 1, 5'h04, 32'hC37F_9A15, 32'hC37F_9A15, 0);

    // Branch decision and pass-through
    add_row(CTRL_BR,  32'h0,  32'h0,         0, 32'h0000_0040, 1, 0, 5'h0, 32'h0,  32'h0,         0);
    add_row(CTRL_BR,  32'h0,  32'h0,         1, 32'h0000_0080, 1, 0, 5'h0, 32'h0,  32'h0,         1);
    add_row(CTRL_NOP, 32'h0,  32'h0,         1, 32'h0000_00C0, 1, 0, 5'h0, 32'h0,  32'h0,         0);
    add_row(CTRL_NOP, 32'h0,  32'h0,         0, 32'h0000_0100, 1, 0, 5'h0, 32'h0,  32'h0,         0);
    add_row(CTRL_JAL, 32'h7C, 32'h0,         1, 32'hFFFF_FFFC, 1, 0, 5'h0, 32'h0,  32'h0,         0);
endtask

`endif

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb
    import mem_stage_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;           // Inputs change shortly after the edge
    localparam int RESET_CYCLES = 2;
    localparam int RAND_SEED    = 25346;
    localparam int N_MEM_BYTES  = 32;
    localparam int N_WORDS      = N_MEM_BYTES / 4;
    localparam int N_RAND       = 24;          // Random store and load pairs
    localparam int N_RAND_CYCLES = N_WORDS + 2 * N_RAND + N_WORDS;

    // Control words in mem_ctrl_t field order
    localparam mem_ctrl_t CTRL_NOP = 11'b000_0_000_0_000;
    localparam mem_ctrl_t CTRL_LW  = 11'b111_0_100_0_000;
    localparam mem_ctrl_t CTRL_LH  = 11'b111_0_010_0_000;
    localparam mem_ctrl_t CTRL_LHU = 11'b111_0_010_1_000;
    localparam mem_ctrl_t CTRL_LB  = 11'b111_0_001_0_000;
    localparam mem_ctrl_t CTRL_LBU = 11'b111_0_001_1_000;
    localparam mem_ctrl_t CTRL_SW  = 11'b000_1_100_0_000;
    localparam mem_ctrl_t CTRL_SH  = 11'b000_1_010_0_000;
    localparam mem_ctrl_t CTRL_SB  = 11'b000_1_001_0_000;
    localparam mem_ctrl_t CTRL_WNR = 11'b000_0_100_0_000;    // Word size, no read
    localparam mem_ctrl_t CTRL_BR  = 11'b000_0_000_0_100;
    localparam mem_ctrl_t CTRL_JAL = 11'b100_0_000_0_011;    // Link write plus halt

    typedef struct packed {
        mem_ctrl_t  ctrl;
        data_word_t addr;
        data_word_t wdata;
        logic       zero;
        pc_t        br_addr;
        logic       dm_en;
        logic       rd_en;
        logic [4:0] rd_addr;
        data_word_t exp_mem;
        data_word_t exp_dbg;
        logic       exp_taken;
    } vec_t;

    logic       i_clock;
    logic       i_rst_n;
    mem_ctrl_t  i_ctrl;
    data_word_t i_alu_result;
    data_word_t i_write_data;
    pc_t        i_branch_addr;
    logic       i_zero;
    reg_idx_t   i_selected_reg;
    pc_t        i_pc;
    logic       i_dm_enable;
    logic       i_dm_read_enable;
    logic [4:0] i_dm_read_address;
    data_word_t o_mem_data;
    data_word_t o_debug_word;
    pc_t        o_branch_addr;
    logic       o_branch_taken;
    wb_bundle_t o_wb;

    vec_t       vec_q [$];
    lane_byte_t shadow [N_MEM_BYTES];      // Expected memory contents for the random part
    int         cycle_count = 0;
    int         step = 0;

    mem_stage #(
        .NB_DATA    (NB_DATA_DEF),
        .NB_PC      (NB_PC_DEF),
        .NB_REG     (NB_REG_DEF),
        .NB_DM_ADDR (NB_DM_ADDR_DEF)
    ) mem_stage_inst (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_ctrl            (i_ctrl),
        .i_alu_result      (i_alu_result),
        .i_write_data      (i_write_data),
        .i_branch_addr     (i_branch_addr),
        .i_zero            (i_zero),
        .i_selected_reg    (i_selected_reg),
        .i_pc              (i_pc),
        .i_dm_enable       (i_dm_enable),
        .i_dm_read_enable  (i_dm_read_enable),
        .i_dm_read_address (i_dm_read_address),
        .o_mem_data        (o_mem_data),
        .o_debug_word      (o_debug_word),
        .o_branch_addr     (o_branch_addr),
        .o_branch_taken    (o_branch_taken),
        .o_wb              (o_wb)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle_count++;
        if (cycle_count > vec_q.size() + N_RAND_CYCLES + 20) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
            halt_run();
        end
    end

    task automatic halt_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_data(input string what, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            halt_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            halt_run();
        end
    endtask

    task automatic check_wb(input string what, input wb_bundle_t got, input wb_bundle_t exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            halt_run();
        end
    endtask

    task automatic add_row(input mem_ctrl_t ctrl, input data_word_t addr, input data_word_t wdata,
                           input logic zero, input pc_t br_addr, input logic dm_en,
                           input logic rd_en, input logic [4:0] rd_addr,
                           input data_word_t exp_mem, input data_word_t exp_dbg,
                           input logic exp_taken);
        vec_t v;
        v = {ctrl, addr, wdata, zero, br_addr, dm_en, rd_en, rd_addr, exp_mem, exp_dbg, exp_taken};
        vec_q.push_back(v);
    endtask

    `include "mem_stage_tb_vectors.svh"

    // Pass-through fields get new values every step
    task automatic apply(input mem_ctrl_t ctrl, input data_word_t addr, input data_word_t wdata,
                         input logic zero, input pc_t br_addr, input logic dm_en,
                         input logic rd_en, input logic [4:0] rd_addr);
        @(posedge i_clock);
        #DRIVE_DELAY;
        i_ctrl            = ctrl;
        i_alu_result      = addr;
        i_write_data      = wdata;
        i_zero            = zero;
        i_branch_addr     = br_addr;
        i_dm_enable       = dm_en;
        i_dm_read_enable  = rd_en;
        i_dm_read_address = rd_addr;
        i_selected_reg    = reg_idx_t'(step);
        i_pc              = pc_t'(32'h0040_0000 + 4 * step);
        step++;
        #(CLK_PERIOD - DRIVE_DELAY - 1);        // Sample just before the next edge
    endtask

    task automatic check_outputs(input string tag, input data_word_t exp_mem,
                                 input data_word_t exp_dbg, input logic exp_taken);
        wb_bundle_t exp_wb;
        exp_wb.reg_write    = i_ctrl.reg_write;
        exp_wb.mem_to_reg   = i_ctrl.mem_to_reg;
        exp_wb.r31_ctrl     = i_ctrl.r31_ctrl;
        exp_wb.hlt          = i_ctrl.hlt;
        exp_wb.selected_reg = i_selected_reg;
        exp_wb.alu_result   = i_alu_result;
        exp_wb.pc           = i_pc;
        check_data({tag, " o_mem_data"}, o_mem_data, exp_mem);
        check_data({tag, " o_debug_word"}, o_debug_word, exp_dbg);
        check_flag({tag, " o_branch_taken"}, o_branch_taken, exp_taken);
        check_data({tag, " o_branch_addr"}, o_branch_addr, i_branch_addr);
        check_wb({tag, " o_wb"}, o_wb, exp_wb);
    endtask

    function automatic data_word_t shadow_word(input int addr);
        return {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    endfunction

    task automatic store_shadow(input int addr, input data_word_t data);
        for (int k = 0; k < 4; k++) begin
            shadow[addr + k] = data[8*k +: 8];     // Little-endian
        end
    endtask

    initial begin
        vec_t       v;
        data_word_t data;
        int         w;
        int         r;
        void'($urandom(RAND_SEED));
        i_rst_n           = 1'b0;
        i_ctrl            = CTRL_NOP;
        i_alu_result      = '0;
        i_write_data      = '0;
        i_branch_addr     = '0;
        i_zero            = 1'b0;
        i_selected_reg    = '0;
        i_pc              = '0;
        i_dm_enable       = 1'b0;
        i_dm_read_enable  = 1'b0;
        i_dm_read_address = '0;
        build_vectors();
        repeat (RESET_CYCLES) @(posedge i_clock);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;

        foreach (vec_q[i]) begin
            v = vec_q[i];
            apply(v.ctrl, v.addr, v.wdata, v.zero, v.br_addr, v.dm_en, v.rd_en, v.rd_addr);
            check_outputs($sformatf("row %0d", i), v.exp_mem, v.exp_dbg, v.exp_taken);
        end

        // Fill every word so the shadow is fully known
        for (int i = 0; i < N_WORDS; i++) begin
            data = $urandom;
            apply(CTRL_SW, 4 * i, data, 1'b0, '0, 1'b1, 1'b0, '0);
            check_outputs($sformatf("fill %0d", i), '0, '0, 1'b0);
            store_shadow(4 * i, data);
        end

        for (int i = 0; i < N_RAND; i++) begin
            w    = $urandom % N_WORDS;
            r    = $urandom % N_WORDS;
            data = $urandom;
            apply(CTRL_SW, 4 * w, data, 1'b0, '0, 1'b1, 1'b1, 5'(4 * r));
            check_outputs($sformatf("random store %0d", i), '0, shadow_word(4 * r), 1'b0);
            store_shadow(4 * w, data);
            w = $urandom % N_WORDS;
            apply(CTRL_LW, 4 * w, '0, 1'b0, '0, 1'b1, 1'b1, 5'(4 * w));
            check_outputs($sformatf("random load %0d", i), shadow_word(4 * w),
                          shadow_word(4 * w), 1'b0);
        end

        for (int i = 0; i < N_WORDS; i++) begin
            apply(CTRL_NOP, '0, '0, 1'b0, '0, 1'b1, 1'b1, 5'(4 * i));
            check_outputs($sformatf("final debug read %0d", i), '0, shadow_word(4 * i), 1'b0);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verification
source/mem_stage_pkg.sv
source/store_aligner.sv
source/byte_lane_bank.sv
source/load_extractor.sv
source/mem_stage.sv
verification/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - source/mem_stage_pkg.sv
      - source/store_aligner.sv
      - source/byte_lane_bank.sv
      - source/load_extractor.sv
      - source/mem_stage.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/mem_stage_tb.sv
